// File: hdl/core_top.sv
// ######################################
// Core top: stages, register file and
// data memory port.
// ######################################
module core_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        inst_req,
    input  logic [31:0] inst,
    input  logic        dmem_ack,
    input  logic [31:0] dmem_rdata,
    output logic        inst_ack,
    output logic        dmem_req,
    output logic [31:0] dmem_addr,
    output logic        commit_valid,
    output logic [4:0]  commit_rd,
    output logic [31:0] commit_data
);

    rv32i_types_pkg::id_ex_reg_t id_ex_reg;
    rv32i_types_pkg::ex_wb_reg_t ex_wb_reg;
    logic                        move;
    logic [4:0]                  rs1_s;
    logic [4:0]                  rs2_s;
    logic [31:0]                 rs1_v;
    logic [31:0]                 rs2_v;
    logic                        regf_we;
    logic [4:0]                  rd_sel;
    logic [31:0]                 rd_v;
    logic                        dmem_resp;
    logic [31:0]                 load_data;

    decode_stage u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst_req  (inst_req),
        .inst      (inst),
        .move      (move),
        .rs1_v     (rs1_v),
        .rs2_v     (rs2_v),
        .ex_wb_reg (ex_wb_reg),
        .inst_ack  (inst_ack),
        .rs1_s     (rs1_s),
        .rs2_s     (rs2_s),
        .id_ex_reg (id_ex_reg)
    );

    execute_stage u_execute (
        .clk       (clk),
        .arst_n    (arst_n),
        .move      (move),
        .id_ex_reg (id_ex_reg),
        .ex_wb_reg (ex_wb_reg)
    );

    writeback_stage u_writeback (
        .ex_wb_reg    (ex_wb_reg),
        .dmem_rdata   (load_data),
        .dmem_resp    (dmem_resp),
        .move         (move),
        .regf_we      (regf_we),
        .rd_sel       (rd_sel),
        .rd_v         (rd_v),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (regf_we),
        .rd_sel (rd_sel),
        .rd_v   (rd_v),
        .rs1_s  (rs1_s),
        .rs2_s  (rs2_s),
        .rs1_v  (rs1_v),
        .rs2_v  (rs2_v)
    );

    dmem_port u_dmem_port (
        .clk           (clk),
        .arst_n        (arst_n),
        .ex_wb_reg     (ex_wb_reg),
        .dmem_ack      (dmem_ack),
        .dmem_rdata_in (dmem_rdata),
        .dmem_req      (dmem_req),
        .dmem_addr     (dmem_addr),
        .dmem_resp     (dmem_resp),
        .dmem_rdata    (load_data)
    );

endmodule

// File: hdl/decode_stage.sv
// ######################################
// Decode stage: instruction handshake,
// field decode and scoreboard interlock.
// ######################################
module decode_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        inst_req,
    input  logic [31:0]                 inst,
    input  logic                        move,
    input  logic [31:0]                 rs1_v,
    input  logic [31:0]                 rs2_v,
    input  rv32i_types_pkg::ex_wb_reg_t ex_wb_reg,
    output logic                        inst_ack,
    output logic [4:0]                  rs1_s,
    output logic [4:0]                  rs2_s,
    output rv32i_types_pkg::id_ex_reg_t id_ex_reg
);

    logic [2:0]                 funct3;
    logic [4:0]                 rd_s;
    rv32i_types_pkg::alu_op_t   alu_op;
    logic                       use_imm;
    logic [31:0]                imm;
    rv32i_types_pkg::wb_ctrl_t  wb_ctrl;
    logic                       uses_rs1;
    logic                       uses_rs2;
    logic                       hit_id;
    logic                       hit_ex;
    logic                       capture;

    assign funct3 = inst[14:12];
    assign rd_s   = inst[11:7];
    assign rs1_s  = inst[19:15];
    assign rs2_s  = inst[24:20];

    always_comb begin
        alu_op           = rv32i_types_pkg::alu_add;
        use_imm          = 1'b1;
        imm              = {{20{inst[31]}}, inst[31:20]};
        wb_ctrl.regf_we  = 1'b0;
        wb_ctrl.rd_m_sel = rv32i_types_pkg::alu_out_rd;
        uses_rs1         = 1'b0;
        uses_rs2         = 1'b0;
        case (inst[6:0])
            rv32i_types_pkg::op_lui: begin
                imm              = {inst[31:12], 12'h000};
                wb_ctrl.regf_we  = 1'b1;
                wb_ctrl.rd_m_sel = rv32i_types_pkg::u_imm_rd;
            end
            rv32i_types_pkg::op_imm, rv32i_types_pkg::op_reg: begin
                uses_rs1        = 1'b1;
                uses_rs2        = (inst[6:0] == rv32i_types_pkg::op_reg);
                use_imm         = !uses_rs2;
                wb_ctrl.regf_we = 1'b1;
                case (funct3)
                    3'b000: alu_op = (uses_rs2 && inst[30]) ? rv32i_types_pkg::alu_sub
                                                             : rv32i_types_pkg::alu_add;
                    3'b010: begin
                        alu_op           = rv32i_types_pkg::alu_slt;
                        wb_ctrl.rd_m_sel = rv32i_types_pkg::cmp_rd;
                    end
                    3'b011: begin
                        alu_op           = rv32i_types_pkg::alu_sltu;
                        wb_ctrl.rd_m_sel = rv32i_types_pkg::cmp_rd;
                    end
                    3'b100: alu_op = rv32i_types_pkg::alu_xor;
                    3'b110: alu_op = rv32i_types_pkg::alu_or;
                    3'b111: alu_op = rv32i_types_pkg::alu_and;
                    // Shifts are not supported.
                    default: wb_ctrl.regf_we = 1'b0;
                endcase
            end
            rv32i_types_pkg::op_load: begin
                uses_rs1        = 1'b1;
                wb_ctrl.regf_we = 1'b1;
                case (funct3)
                    3'b000:  wb_ctrl.rd_m_sel = rv32i_types_pkg::lb;
                    3'b001:  wb_ctrl.rd_m_sel = rv32i_types_pkg::lh;
                    3'b010:  wb_ctrl.rd_m_sel = rv32i_types_pkg::lw;
                    3'b100:  wb_ctrl.rd_m_sel = rv32i_types_pkg::lbu;
                    3'b101:  wb_ctrl.rd_m_sel = rv32i_types_pkg::lhu;
                    default: wb_ctrl.regf_we  = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    // A source register still being produced further down blocks the handshake.
    assign hit_id = id_ex_reg.valid_s && id_ex_reg.wb_ctrl_s.regf_we
                 && (id_ex_reg.rd_s_s != 5'd0)
                 && ((uses_rs1 && id_ex_reg.rd_s_s == rs1_s)
                  || (uses_rs2 && id_ex_reg.rd_s_s == rs2_s));
    assign hit_ex = ex_wb_reg.valid_s && ex_wb_reg.wb_ctrl_s.regf_we
                 && (ex_wb_reg.rd_s_s != 5'd0)
                 && ((uses_rs1 && ex_wb_reg.rd_s_s == rs1_s)
                  || (uses_rs2 && ex_wb_reg.rd_s_s == rs2_s));

    assign capture = inst_req && !inst_ack && move && !hit_id && !hit_ex;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst_ack  <= 1'b0;
            id_ex_reg <= '0;
        end else begin
            if (capture) begin
                inst_ack <= 1'b1;
            end else if (!inst_req) begin
                inst_ack <= 1'b0;
            end
            if (move) begin
                id_ex_reg.valid_s   <= capture;
                id_ex_reg.alu_op_s  <= alu_op;
                id_ex_reg.use_imm_s <= use_imm;
                id_ex_reg.imm_s     <= imm;
                id_ex_reg.rs1_v_s   <= rs1_v;
                id_ex_reg.rs2_v_s   <= rs2_v;
                id_ex_reg.rd_s_s    <= rd_s;
                id_ex_reg.wb_ctrl_s <= wb_ctrl;
            end
        end
    end

    ack_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(inst_ack) |-> $past(inst_req))
        else $error("inst_ack rose without inst_req");

endmodule

// File: hdl/dmem_port.sv
// ######################################
// Four-phase read master to data memory.
// ######################################
module dmem_port (
    input  logic                        clk,
    input  logic                        arst_n,
    input  rv32i_types_pkg::ex_wb_reg_t ex_wb_reg,
    input  logic                        dmem_ack,
    input  logic [31:0]                 dmem_rdata_in,
    output logic                        dmem_req,
    output logic [31:0]                 dmem_addr,
    output logic                        dmem_resp,
    output logic [31:0]                 dmem_rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_release,
        st_resp
    } state_t;

    state_t state;
    logic   load_pending;

    assign load_pending = ex_wb_reg.valid_s
                       && rv32i_types_pkg::is_load(ex_wb_reg.wb_ctrl_s.rd_m_sel);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    if (load_pending) state <= st_req;
                st_req:     if (dmem_ack) state <= st_release;
                st_release: if (!dmem_ack) state <= st_resp;
                default:    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_req && dmem_ack) begin
            dmem_rdata <= dmem_rdata_in;
        end
    end

    // The address is stable since the load holds the pipe.
    assign dmem_addr = {ex_wb_reg.mem_addr_s[31:2], 2'b00};
    assign dmem_req  = (state == st_req);
    assign dmem_resp = (state == st_resp);

    req_held_for_ack: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(dmem_req) |-> $past(dmem_ack))
        else $error("dmem_req dropped before dmem_ack");

endmodule

// File: hdl/execute_stage.sv
// ######################################
// Execute stage: ALU, compare unit and
// load address generation.
// ######################################
module execute_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        move,
    input  rv32i_types_pkg::id_ex_reg_t id_ex_reg,
    output rv32i_types_pkg::ex_wb_reg_t ex_wb_reg
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic [31:0] mem_addr;
    logic        cmp;

    assign op_a = id_ex_reg.rs1_v_s;
    assign op_b = id_ex_reg.use_imm_s ? id_ex_reg.imm_s : id_ex_reg.rs2_v_s;

    always_comb begin
        if (id_ex_reg.alu_op_s == rv32i_types_pkg::alu_sltu) begin
            cmp = (op_a < op_b);
        end else begin
            cmp = ($signed(op_a) < $signed(op_b));
        end
    end

    always_comb begin
        case (id_ex_reg.alu_op_s)
            rv32i_types_pkg::alu_sub:  alu_out = op_a - op_b;
            rv32i_types_pkg::alu_xor:  alu_out = op_a ^ op_b;
            rv32i_types_pkg::alu_or:   alu_out = op_a | op_b;
            rv32i_types_pkg::alu_and:  alu_out = op_a & op_b;
            default:                   alu_out = op_a + op_b;
        endcase
    end

    // Effective address of a load.
    assign mem_addr = op_a + id_ex_reg.imm_s;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_wb_reg <= '0;
        end else if (move) begin
            ex_wb_reg.valid_s   <= id_ex_reg.valid_s;
            ex_wb_reg.rd_s_s    <= id_ex_reg.rd_s_s;
            ex_wb_reg.wb_ctrl_s <= id_ex_reg.wb_ctrl_s;
            ex_wb_reg.alu_out_s <= alu_out;
            ex_wb_reg.u_imm_s   <= id_ex_reg.imm_s;
            ex_wb_reg.cmp_s     <= cmp;
            if (rv32i_types_pkg::is_load(id_ex_reg.wb_ctrl_s.rd_m_sel)) begin
                ex_wb_reg.mem_addr_s <= mem_addr;
            end
        end
    end

endmodule

// File: hdl/regfile.sv
// ######################################
// Register file, 32 x 32 bits, 2R1W.
// ######################################
module regfile (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        we,
    input  logic [4:0]  rd_sel,
    input  logic [31:0] rd_v,
    input  logic [4:0]  rs1_s,
    input  logic [4:0]  rs2_s,
    output logic [31:0] rs1_v,
    output logic [31:0] rs2_v
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_sel != 5'd0) begin
            regs[rd_sel] <= rd_v;
        end
    end

    // Write data passes straight through to a read of the same index.
    assign rs1_v = (rs1_s == 5'd0)              ? '0
                 : (we && rd_sel == rs1_s)      ? rd_v
                 :                                regs[rs1_s];
    assign rs2_v = (rs2_s == 5'd0)              ? '0
                 : (we && rd_sel == rs2_s)      ? rd_v
                 :                                regs[rs2_s];

endmodule

// File: hdl/rv32i_types_pkg.sv
// ######################################
// Opcode and result-select enums, pipeline
// register structs and the load test.
// ######################################
package rv32i_types_pkg;

    // Major opcodes of the supported subset.
    typedef enum logic [6:0] {
        op_lui  = 7'b0110111,
        op_imm  = 7'b0010011,
        op_reg  = 7'b0110011,
        op_load = 7'b0000011
    } opcode_t;

    // Write-back source.
    typedef enum logic [3:0] {
        u_imm_rd,
        alu_out_rd,
        cmp_rd,
        lb,
        lbu,
        lh,
        lhu,
        lw
    } rd_m_sel_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_xor,
        alu_or,
        alu_and,
        alu_slt,
        alu_sltu
    } alu_op_t;

    typedef struct packed {
        logic      regf_we;
        rd_m_sel_t rd_m_sel;
    } wb_ctrl_t;

    typedef struct packed {
        logic        valid_s;
        alu_op_t     alu_op_s;
        logic        use_imm_s;
        logic [31:0] imm_s;
        logic [31:0] rs1_v_s;
        logic [31:0] rs2_v_s;
        logic [4:0]  rd_s_s;
        wb_ctrl_t    wb_ctrl_s;
    } id_ex_reg_t;

    typedef struct packed {
        logic        valid_s;
        logic [4:0]  rd_s_s;
        wb_ctrl_t    wb_ctrl_s;
        logic [31:0] alu_out_s;
        logic [31:0] u_imm_s;
        logic [31:0] mem_addr_s;
        logic        cmp_s;
    } ex_wb_reg_t;

    function automatic logic is_load(input rd_m_sel_t sel);
        return sel inside {lb, lbu, lh, lhu, lw};
    endfunction

endpackage

// File: hdl/writeback_stage.sv
// ######################################
// Write-back stage: result mux, load lane
// extraction, register write and commit.
// ######################################
module writeback_stage (
    input  rv32i_types_pkg::ex_wb_reg_t ex_wb_reg,
    input  logic [31:0]                 dmem_rdata,
    input  logic                        dmem_resp,
    output logic                        move,
    output logic                        regf_we,
    output logic [4:0]                  rd_sel,
    output logic [31:0]                 rd_v,
    output logic                        commit_valid,
    output logic [4:0]                  commit_rd,
    output logic [31:0]                 commit_data
);

    rv32i_types_pkg::wb_ctrl_t wb_ctrl;
    logic                      load;
    logic                      valid;
    logic [7:0]                byte_v;
    logic [15:0]               half_v;

    assign wb_ctrl = ex_wb_reg.wb_ctrl_s;
    assign load    = ex_wb_reg.valid_s && rv32i_types_pkg::is_load(wb_ctrl.rd_m_sel);

    // A load holds the whole pipe until its data comes back.
    assign move  = !load || dmem_resp;
    assign valid = load ? dmem_resp : (ex_wb_reg.valid_s && move);

    assign byte_v = dmem_rdata[{ex_wb_reg.mem_addr_s[1:0], 3'b000} +: 8];
    assign half_v = dmem_rdata[{ex_wb_reg.mem_addr_s[1], 4'b0000} +: 16];

    always_comb begin
        case (wb_ctrl.rd_m_sel)
            rv32i_types_pkg::u_imm_rd: rd_v = ex_wb_reg.u_imm_s;
            rv32i_types_pkg::cmp_rd:   rd_v = {31'd0, ex_wb_reg.cmp_s};
            rv32i_types_pkg::lb:       rd_v = {{24{byte_v[7]}}, byte_v};
            rv32i_types_pkg::lbu:      rd_v = {24'd0, byte_v};
            rv32i_types_pkg::lh:       rd_v = {{16{half_v[15]}}, half_v};
            rv32i_types_pkg::lhu:      rd_v = {16'd0, half_v};
            rv32i_types_pkg::lw:       rd_v = dmem_rdata;
            default:                   rd_v = ex_wb_reg.alu_out_s;
        endcase
    end

    assign regf_we = valid && wb_ctrl.regf_we;
    assign rd_sel  = ex_wb_reg.rd_s_s;

    // Every register write is reported, x0 included.
    assign commit_valid = regf_we;
    assign commit_rd    = rd_sel;
    assign commit_data  = rd_v;

    resp_needs_load: assert property (@(posedge dmem_resp) load)
        else $error("dmem_resp without a pending load");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and scan the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 -f vlog.f --top-module tb_core_top \
    -Mdir obj_dir -o sim_core
if [ $? -ne 0 ]; then
    echo "Verilator build returned an error"
    exit 1
fi

./obj_dir/sim_core > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

// File: test/tb_vectors.svh
// ######################################
// Instruction table with expected commits
// and the data memory image.
// ######################################
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: instruction word, commits, rd, expected value of rd.
typedef struct packed {
    logic [31:0] inst;
    logic        commits;
    logic [4:0]  rd;
    logic [31:0] value;
} vec_t;

localparam int NUM_VEC = 31;

vec_t vectors [NUM_VEC] = '{
    // Immediate ops, SLTI against SLTIU on a negative operand, then LUI.
    {32'h00500093, 1'b1, 5'd1,  32'h00000005},
    {32'hFFD00113, 1'b1, 5'd2,  32'hFFFFFFFD},
    {32'h00112193, 1'b1, 5'd3,  32'h00000001},
    {32'h00113213, 1'b1, 5'd4,  32'h00000000},
    {32'hFFF0C293, 1'b1, 5'd5,  32'hFFFFFFFA},
    {32'h0F00E313, 1'b1, 5'd6,  32'h000000F5},
    {32'h03C37393, 1'b1, 5'd7,  32'h00000034},
    {32'hABCDE437, 1'b1, 5'd8,  32'hABCDE000},
    // Register-register ops.
    {32'h001404B3, 1'b1, 5'd9,  32'hABCDE005},
    {32'h40208533, 1'b1, 5'd10, 32'h00000008},
    {32'h0054C5B3, 1'b1, 5'd11, 32'h54321FFF},
    {32'h00756633, 1'b1, 5'd12, 32'h0000003C},
    {32'h0095F6B3, 1'b1, 5'd13, 32'h00000005},
    {32'h00112733, 1'b1, 5'd14, 32'h00000001},
    {32'h001137B3, 1'b1, 5'd15, 32'h00000000},
    // A write to x0 still commits, a later read of x0 gives zero.
    {32'h00708013, 1'b1, 5'd0,  32'h0000000C},
    {32'h00100833, 1'b1, 5'd16, 32'h00000005},
    // Loads at every byte offset.
    {32'h00000883, 1'b1, 5'd17, 32'hFFFFFFC5},
    {32'h00100903, 1'b1, 5'd18, 32'h00000041},
    {32'h00204983, 1'b1, 5'd19, 32'h00000080},
    {32'h00300A03, 1'b1, 5'd20, 32'h0000007F},
    {32'h00004A83, 1'b1, 5'd21, 32'h000000C5},
    {32'h00200B03, 1'b1, 5'd22, 32'hFFFFFF80},
    {32'h00401B83, 1'b1, 5'd23, 32'hFFFFFF23},
    {32'h00605C03, 1'b1, 5'd24, 32'h00008001},
    {32'h00201C83, 1'b1, 5'd25, 32'h00007F80},
    {32'h00C02D03, 1'b1, 5'd26, 32'hDEADBEEF},
    // Load-use, a store that retires as a no-op, then a dependent ADD.
    {32'h001D0D93, 1'b1, 5'd27, 32'hDEADBEF0},
    {32'hFFF0DE03, 1'b1, 5'd28, 32'h0000FF23},
    {32'h00102023, 1'b0, 5'd0,  32'h00000000},
    {32'h01CD8EB3, 1'b1, 5'd29, 32'hDEAEBE13}
};

// Word i sits at byte address 4 * i.
logic [31:0] mem_image [8] = '{
    32'h7F8041C5, 32'h8001FF23, 32'h12345678, 32'hDEADBEEF,
    32'h00000005, 32'hCAFE0042, 32'h0F0FF0F0, 32'h80000000
};

`endif

// File: test/tb_core_top.sv
// ######################################
// Testbench for the core: instruction
// source, memory responder, commit checks.
// ######################################
module tb_core_top;

    `include "tb_vectors.svh"

    localparam int TIMEOUT = 200;

    logic        clk;
    logic        arst_n;
    logic        inst_req;
    logic [31:0] inst;
    logic        dmem_ack;
    logic [31:0] dmem_rdata;
    logic        inst_ack;
    logic        dmem_req;
    logic [31:0] dmem_addr;
    logic        commit_valid;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;

    integer seed = 32'h598c;
    int     pass_count;
    int     fail_count;
    int     acked;
    logic   abort;
    logic   checker_done;

    core_top dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_req     (inst_req),
        .inst         (inst),
        .dmem_ack     (dmem_ack),
        .dmem_rdata   (dmem_rdata),
        .inst_ack     (inst_ack),
        .dmem_req     (dmem_req),
        .dmem_addr    (dmem_addr),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        fail_count++;
        abort = 1'b1;
    endtask

    task automatic check_reset();
        logic ok;
        ok = 1'b1;
        if (inst_ack !== 1'b0) begin
            $display("ERROR at %0t: inst_ack expected 0 got %b", $time, inst_ack);
            ok = 1'b0;
        end
        if (dmem_req !== 1'b0) begin
            $display("ERROR at %0t: dmem_req expected 0 got %b", $time, dmem_req);
            ok = 1'b0;
        end
        if (commit_valid !== 1'b0) begin
            $display("ERROR at %0t: commit_valid expected 0 got %b", $time, commit_valid);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test reset %s", ok ? "ok" : "mismatch");
    endtask

    // Four-phase source, one table entry per handshake.
    task automatic run_source();
        int cycles;
        for (int i = 0; i < NUM_VEC; i++) begin
            if (abort) begin
                break;
            end
            inst     = vectors[i].inst;
            inst_req = 1'b1;
            cycles   = 0;
            while (!inst_ack && !abort) begin
                @(posedge clk);
                #2;
                cycles++;
                if (cycles > TIMEOUT) begin
                    report_timeout("inst_ack to rise");
                end
            end
            if (inst_ack) begin
                acked++;
            end
            inst_req = 1'b0;
            cycles   = 0;
            while (inst_ack && !abort) begin
                @(posedge clk);
                #2;
                cycles++;
                if (cycles > TIMEOUT) begin
                    report_timeout("inst_ack to fall");
                end
            end
        end
    endtask

    task automatic check_commits();
        int   cycles;
        logic ok;
        for (int i = 0; i < NUM_VEC; i++) begin
            if (abort) begin
                break;
            end
            cycles = 0;
            ok     = 1'b1;
            if (!vectors[i].commits) begin
                while (acked <= i && !abort) begin
                    @(negedge clk);
                    cycles++;
                    if (cycles > TIMEOUT) begin
                        report_timeout("an unsupported instruction to be acknowledged");
                    end
                end
                // It leaves write-back within two cycles of its acknowledge.
                for (int c = 0; c < 2; c++) begin
                    @(negedge clk);
                    if (commit_valid) begin
                        $display("Unexpected commit to x%0d at %0t for an instruction %s",
                                 commit_rd, $time, "that writes no register");
                        ok = 1'b0;
                    end
                end
            end else begin
                @(negedge clk);
                while (!commit_valid && !abort) begin
                    @(negedge clk);
                    cycles++;
                    if (cycles > TIMEOUT) begin
                        report_timeout("a commit");
                    end
                end
                if (!abort && commit_rd !== vectors[i].rd) begin
                    $display("ERROR at %0t: commit_rd expected %0d got %0d",
                             $time, vectors[i].rd, commit_rd);
                    ok = 1'b0;
                end
                if (!abort && commit_data !== vectors[i].value) begin
                    $display("ERROR at %0t: commit_data expected %h got %h",
                             $time, vectors[i].value, commit_data);
                    ok = 1'b0;
                end
            end
            if (abort) begin
                break;
            end
            if (ok) begin
                pass_count++;
            end else begin
                fail_count++;
            end
            $display("test %0d %s: inst %h", i, ok ? "ok" : "mismatch", vectors[i].inst);
        end
        checker_done = 1'b1;
    endtask

    // Answers each read from the image after 0 to 3 idle cycles.
    task automatic serve_memory();
        int delay;
        int cycles;
        while (!checker_done && !abort) begin
            @(posedge clk);
            #2;
            if (dmem_req) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                if (dmem_addr[31:5] != 27'd0 || dmem_addr[1:0] != 2'b00) begin
                    $display("Load address %h at %0t is not a word of the memory image",
                             dmem_addr, $time);
                    fail_count++;
                end
                dmem_rdata = mem_image[dmem_addr[4:2]];
                dmem_ack   = 1'b1;
                cycles     = 0;
                while (dmem_req && !abort) begin
                    @(posedge clk);
                    #2;
                    cycles++;
                    if (cycles > TIMEOUT) begin
                        report_timeout("dmem_req to fall");
                    end
                end
                dmem_ack = 1'b0;
            end
        end
    endtask

    initial begin
        arst_n       = 1'b0;
        inst_req     = 1'b0;
        inst         = 32'h0;
        dmem_ack     = 1'b0;
        dmem_rdata   = 32'h0;
        pass_count   = 0;
        fail_count   = 0;
        acked        = 0;
        abort        = 1'b0;
        checker_done = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;
        check_reset();
        fork
            run_source();
            check_commits();
            serve_memory();
        join
        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+test
hdl/rv32i_types_pkg.sv
hdl/regfile.sv
hdl/dmem_port.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/core_top.sv
test/tb_core_top.sv
